// File: common/arm_cfg.svh
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

`define ARM_WORD_W   32            // data and address width
`define ARM_REG_N    16

// first fetch address after reset
`define ARM_RESET_PC 32'h0000_0000

`define ARM_PC_AHEAD 8             // pc reads two instructions ahead

`endif

// File: common/arm_isa_pkg.sv
package arm_isa_pkg;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL, COND_NV
    } cond_e;

    typedef enum logic [3:0] {
        OP_AND, OP_EOR, OP_SUB, OP_RSB,
        OP_ADD, OP_ADC, OP_SBC, OP_RSC,
        OP_TST, OP_TEQ, OP_CMP, OP_CMN,
        OP_ORR, OP_MOV, OP_BIC, OP_MVN
    } dp_op_e;

    typedef enum logic [1:0] {
        CLS_DP,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH
    } inst_class_e;

    localparam int unsigned COND_LSB = 28;
    localparam int unsigned BIT_IMM  = 25;
    localparam int unsigned BIT_UP   = 23;    // load/store offset sign
    localparam int unsigned OP_LSB   = 21;
    localparam int unsigned BIT_SET  = 20;    // S bit, or L bit for load/store
    localparam int unsigned RN_LSB   = 16;
    localparam int unsigned RD_LSB   = 12;

endpackage

// File: common/arm_core_pkg.sv
`include "arm_cfg.svh"

package arm_core_pkg;

    typedef logic [`ARM_WORD_W-1:0] word_t;

    typedef logic [$clog2(`ARM_REG_N)-1:0] reg_code_t;

    // ordered n, z, c, v from msb
    typedef logic [3:0] nzcv_t;

endpackage

// File: core/arm_fetch.sv
`timescale 1ns/1ps
`include "arm_cfg.svh"

module arm_fetch (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_stall,
    input  logic                i_branch,
    input  arm_core_pkg::word_t i_branch_target,
    output logic                o_rom_en,
    output arm_core_pkg::word_t o_rom_addr,
    output logic                o_inst_vld,
    output arm_core_pkg::word_t o_inst_addr
);
    import arm_core_pkg::*;

    word_t pc;

    assign o_rom_en   = ~i_stall;     // rom word holds while decode stalls
    assign o_rom_addr = pc;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc         <= `ARM_RESET_PC;
            o_inst_vld <= 1'b0;
        end else if (i_branch) begin
            pc         <= i_branch_target;
            o_inst_vld <= 1'b0;       // word requested this cycle is on the wrong path
        end else if (o_rom_en) begin
            pc         <= pc + 32'd4;
            o_inst_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_rom_en)
            o_inst_addr <= pc;        // address of the word now in flight
    end

endmodule

// File: core/arm_decoder.sv
`timescale 1ns/1ps
`include "arm_cfg.svh"

module arm_decoder (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_inst_vld,
    input  arm_core_pkg::word_t      i_inst,
    input  arm_core_pkg::word_t      i_inst_addr,
    input  logic                     i_flush,
    input  logic                     i_ex_load,
    input  arm_core_pkg::reg_code_t  i_ex_rd_code,
    input  arm_core_pkg::word_t      i_rn_value,
    input  arm_core_pkg::word_t      i_rm_value,
    input  arm_core_pkg::word_t      i_rd_value,
    output arm_core_pkg::reg_code_t  o_rn_code,
    output arm_core_pkg::reg_code_t  o_rm_code,
    output arm_core_pkg::reg_code_t  o_rd_code,
    output logic                     o_stall,
    output logic                     o_vld,
    output arm_isa_pkg::inst_class_e o_class,
    output arm_isa_pkg::dp_op_e      o_op,
    output arm_isa_pkg::cond_e       o_cond,
    output logic                     o_set_flags,
    output arm_core_pkg::word_t      o_op_a,
    output arm_core_pkg::word_t      o_op_b,
    output arm_core_pkg::word_t      o_store_data,
    output arm_core_pkg::reg_code_t  o_dest,
    output logic                     o_writes_rd,
    output arm_core_pkg::word_t      o_target
);
    import arm_isa_pkg::*;
    import arm_core_pkg::*;

    inst_class_e               cls;
    dp_op_e                    op;
    logic                      known;
    logic                      compare;
    logic                      use_rn, use_rm, use_rd;
    logic [2*`ARM_WORD_W-1:0]  imm_dbl;
    word_t                     ls_off;
    word_t                     op_b;

    assign o_rn_code = i_inst[RN_LSB +: 4];
    assign o_rm_code = i_inst[3:0];
    assign o_rd_code = i_inst[RD_LSB +: 4];

    always_comb begin
        known = 1'b1;
        case (i_inst[27:26])
            2'b00:   cls = CLS_DP;
            2'b01:   cls = i_inst[BIT_SET] ? CLS_LOAD : CLS_STORE;
            2'b10:   cls = CLS_BRANCH;
            default: begin
                cls   = CLS_DP;
                known = 1'b0;          // coprocessor space, dropped as a bubble
            end
        endcase
    end

    // memory ops use the adder for base plus offset
    assign op      = (cls == CLS_DP) ? dp_op_e'(i_inst[OP_LSB +: 4]) : OP_ADD;
    assign compare = op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};

    assign use_rn  = (cls != CLS_BRANCH) && !(cls == CLS_DP && op inside {OP_MOV, OP_MVN});
    assign use_rm  = (cls == CLS_DP) && !i_inst[BIT_IMM];
    assign use_rd  = (cls == CLS_STORE);

    // load in execute feeding a source here: one bubble, then take it from writeback
    assign o_stall = i_inst_vld && known && i_ex_load &&
                     ((use_rn && o_rn_code == i_ex_rd_code) ||
                      (use_rm && o_rm_code == i_ex_rd_code) ||
                      (use_rd && o_rd_code == i_ex_rd_code));

    assign imm_dbl = {word_t'(i_inst[7:0]), word_t'(i_inst[7:0])} >> {i_inst[11:8], 1'b0};
    assign ls_off  = word_t'(i_inst[11:0]);

    always_comb begin
        if (cls == CLS_DP)
            op_b = i_inst[BIT_IMM] ? imm_dbl[`ARM_WORD_W-1:0] : i_rm_value;
        else
            op_b = i_inst[BIT_UP] ? ls_off : -ls_off;
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            o_vld <= 1'b0;
        else
            o_vld <= i_inst_vld && known && !i_flush && !o_stall;
    end

    always_ff @(posedge clk) begin
        o_class      <= cls;
        o_op         <= op;
        o_cond       <= cond_e'(i_inst[COND_LSB +: 4]);
        o_set_flags  <= (cls == CLS_DP) && i_inst[BIT_SET];
        o_op_a       <= i_rn_value;
        o_op_b       <= op_b;
        o_store_data <= i_rd_value;
        o_dest       <= o_rd_code;
        o_writes_rd  <= (cls == CLS_DP && !compare) || cls == CLS_LOAD;
        o_target     <= i_inst_addr + `ARM_PC_AHEAD + {{6{i_inst[23]}}, i_inst[23:0], 2'b00};
    end

endmodule

// File: core/arm_regfile.sv
`timescale 1ns/1ps
`include "arm_cfg.svh"

module arm_regfile (
    input  logic                    clk,
    input  logic                    i_rst,
    input  arm_core_pkg::reg_code_t i_rn_code,
    input  arm_core_pkg::reg_code_t i_rm_code,
    input  arm_core_pkg::reg_code_t i_rd_code,
    input  logic                    i_ex_en,
    input  arm_core_pkg::reg_code_t i_ex_code,
    input  arm_core_pkg::word_t     i_ex_value,
    input  logic                    i_wb_en,
    input  arm_core_pkg::reg_code_t i_wb_code,
    input  arm_core_pkg::word_t     i_wb_value,
    output arm_core_pkg::word_t     o_rn_value,
    output arm_core_pkg::word_t     o_rm_value,
    output arm_core_pkg::word_t     o_rd_value
);
    import arm_core_pkg::*;

    word_t regs [`ARM_REG_N];

    // youngest producer wins
    function automatic word_t read_port(input reg_code_t code);
        if (i_ex_en && i_ex_code == code)
            return i_ex_value;
        if (i_wb_en && i_wb_code == code)
            return i_wb_value;
        return regs[code];
    endfunction

    always_comb begin
        o_rn_value = read_port(i_rn_code);
        o_rm_value = read_port(i_rm_code);
        o_rd_value = read_port(i_rd_code);      // store data
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `ARM_REG_N; i++)
                regs[i] <= '0;
        end else if (i_wb_en) begin
            regs[i_wb_code] <= i_wb_value;
        end
    end

endmodule

// File: core/arm_execute.sv
`timescale 1ns/1ps
`include "arm_cfg.svh"

module arm_execute (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_vld,
    input  arm_isa_pkg::inst_class_e i_class,
    input  arm_isa_pkg::dp_op_e      i_op,
    input  arm_isa_pkg::cond_e       i_cond,
    input  logic                     i_set_flags,
    input  arm_core_pkg::word_t      i_op_a,
    input  arm_core_pkg::word_t      i_op_b,
    input  arm_core_pkg::word_t      i_store_data,
    input  arm_core_pkg::reg_code_t  i_dest,
    input  logic                     i_writes_rd,
    input  arm_core_pkg::word_t      i_target,
    output logic                     o_res_en,
    output arm_core_pkg::reg_code_t  o_res_code,
    output arm_core_pkg::word_t      o_res_value,
    output logic                     o_load,
    output logic                     o_branch,
    output arm_core_pkg::word_t      o_branch_target,
    output logic                     o_ram_en,
    output logic                     o_ram_wr,
    output arm_core_pkg::word_t      o_ram_addr,
    output arm_core_pkg::word_t      o_ram_wdata
);
    import arm_isa_pkg::*;
    import arm_core_pkg::*;

    nzcv_t                flags;
    logic                 pass, exec, nop, arith, ovf;
    logic                 add_cin;
    word_t                add_x, add_y, alu;
    logic [`ARM_WORD_W:0] sum;

    always_comb begin
        case (i_cond)
            COND_EQ: pass = flags[2];
            COND_NE: pass = !flags[2];
            COND_CS: pass = flags[1];
            COND_CC: pass = !flags[1];
            COND_MI: pass = flags[3];
            COND_PL: pass = !flags[3];
            COND_VS: pass = flags[0];
            COND_VC: pass = !flags[0];
            COND_HI: pass = flags[1] && !flags[2];
            COND_LS: pass = !flags[1] || flags[2];
            COND_GE: pass = flags[3] == flags[0];
            COND_LT: pass = flags[3] != flags[0];
            COND_GT: pass = !flags[2] && flags[3] == flags[0];
            COND_LE: pass = flags[2] || flags[3] != flags[0];
            COND_AL: pass = 1'b1;
            default: pass = 1'b0;
        endcase
    end

    assign exec = i_vld && pass;

    // subtraction as x + ~y + 1, so c is not-borrow
    always_comb begin
        add_x   = i_op_a;
        add_y   = i_op_b;
        add_cin = 1'b0;
        if (i_op inside {OP_SUB, OP_CMP}) begin
            add_y   = ~i_op_b;
            add_cin = 1'b1;
        end else if (i_op == OP_RSB) begin
            add_x   = i_op_b;
            add_y   = ~i_op_a;
            add_cin = 1'b1;
        end
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + (`ARM_WORD_W+1)'(add_cin);
    assign ovf = (add_x[`ARM_WORD_W-1] == add_y[`ARM_WORD_W-1]) &&
                 (sum[`ARM_WORD_W-1] != add_x[`ARM_WORD_W-1]);

    always_comb begin
        nop   = 1'b0;
        arith = 1'b0;
        alu   = sum[`ARM_WORD_W-1:0];
        case (i_op)
            OP_AND, OP_TST: alu = i_op_a & i_op_b;
            OP_EOR, OP_TEQ: alu = i_op_a ^ i_op_b;
            OP_ORR:         alu = i_op_a | i_op_b;
            OP_BIC:         alu = i_op_a & ~i_op_b;
            OP_MOV:         alu = i_op_b;
            OP_MVN:         alu = ~i_op_b;
            OP_ADD, OP_SUB, OP_RSB, OP_CMP, OP_CMN: arith = 1'b1;
            default:        nop = 1'b1;     // carry-in ops are not supported
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            flags <= '0;
        else if (exec && i_class == CLS_DP && !nop &&
                 (i_set_flags || i_op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}))
            flags <= {alu[`ARM_WORD_W-1], alu == '0,
                      arith ? sum[`ARM_WORD_W] : flags[1],
                      arith ? ovf : flags[0]};  // logical ops keep c and v
    end

    assign o_res_en    = exec && i_writes_rd && !nop;
    assign o_res_code  = i_dest;
    assign o_res_value = alu;           // load data is picked up in writeback
    assign o_load      = exec && i_class == CLS_LOAD;

    assign o_branch        = exec && i_class == CLS_BRANCH;
    assign o_branch_target = i_target;

    assign o_ram_en    = exec && (i_class == CLS_LOAD || i_class == CLS_STORE);
    assign o_ram_wr    = i_class == CLS_STORE;
    assign o_ram_addr  = alu;
    assign o_ram_wdata = i_store_data;

endmodule

// File: core/arm_writeback.sv
`timescale 1ns/1ps

module arm_writeback (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_res_en,
    input  arm_core_pkg::reg_code_t i_res_code,
    input  arm_core_pkg::word_t     i_res_value,
    input  logic                    i_load,
    input  arm_core_pkg::word_t     i_ram_rdata,
    output logic                    o_wb_en,
    output arm_core_pkg::reg_code_t o_wb_code,
    output arm_core_pkg::word_t     o_wb_value
);
    import arm_core_pkg::*;

    logic  load_q;
    word_t value_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            o_wb_en <= i_res_en;
            load_q  <= i_load;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_code <= i_res_code;
        value_q   <= i_res_value;
    end

    assign o_wb_value = load_q ? i_ram_rdata : value_q;   // ram answers one cycle after request

endmodule

// File: core/arm_core.sv
`timescale 1ns/1ps

module arm_core (
    input  logic                clk,
    input  logic                i_rst,

    // rom bus
    output logic                o_rom_en,
    output arm_core_pkg::word_t o_rom_addr,
    input  arm_core_pkg::word_t i_rom_data,

    // ram bus
    output logic                o_ram_en,
    output logic                o_ram_wr,
    output arm_core_pkg::word_t o_ram_addr,
    input  arm_core_pkg::word_t i_ram_rdata,
    output arm_core_pkg::word_t o_ram_wdata
);
    import arm_isa_pkg::*;
    import arm_core_pkg::*;

    logic        stall, branch, inst_vld;
    word_t       branch_target, inst_addr;
    reg_code_t   rn_code, rm_code, rd_code;
    word_t       rn_value, rm_value, rd_value;

    logic        id_vld, id_set_flags, id_writes_rd;
    inst_class_e id_class;
    dp_op_e      id_op;
    cond_e       id_cond;
    word_t       id_op_a, id_op_b, id_store_data, id_target;
    reg_code_t   id_dest;

    logic        ex_en, ex_load;
    reg_code_t   ex_code;
    word_t       ex_value;

    logic        wb_en;
    reg_code_t   wb_code;
    word_t       wb_value;

    arm_fetch arm_fetch_0 (
        .clk            (clk            ), .i_rst       (i_rst          ),
        .i_stall        (stall          ),
        .i_branch       (branch         ), .i_branch_target (branch_target),
        .o_rom_en       (o_rom_en       ), .o_rom_addr  (o_rom_addr     ),
        .o_inst_vld     (inst_vld       ), .o_inst_addr (inst_addr      )
    );

    arm_decoder arm_decoder_0 (
        .clk            (clk            ), .i_rst       (i_rst          ),
        .i_inst_vld     (inst_vld       ), .i_inst      (i_rom_data     ),
        .i_inst_addr    (inst_addr      ), .i_flush     (branch         ),
        .i_ex_load      (ex_load        ), .i_ex_rd_code (ex_code       ),
        .i_rn_value     (rn_value       ), .i_rm_value  (rm_value       ),
        .i_rd_value     (rd_value       ),
        .o_rn_code      (rn_code        ), .o_rm_code   (rm_code        ),
        .o_rd_code      (rd_code        ), .o_stall     (stall          ),
        .o_vld          (id_vld         ), .o_class     (id_class       ),
        .o_op           (id_op          ), .o_cond      (id_cond        ),
        .o_set_flags    (id_set_flags   ), .o_op_a      (id_op_a        ),
        .o_op_b         (id_op_b        ), .o_store_data (id_store_data ),
        .o_dest         (id_dest        ), .o_writes_rd (id_writes_rd   ),
        .o_target       (id_target      )
    );

    arm_regfile arm_regfile_0 (
        .clk            (clk            ), .i_rst       (i_rst          ),
        .i_rn_code      (rn_code        ), .i_rm_code   (rm_code        ),
        .i_rd_code      (rd_code        ),
        .i_ex_en        (ex_en          ), .i_ex_code   (ex_code        ),
        .i_ex_value     (ex_value       ),
        .i_wb_en        (wb_en          ), .i_wb_code   (wb_code        ),
        .i_wb_value     (wb_value       ),
        .o_rn_value     (rn_value       ), .o_rm_value  (rm_value       ),
        .o_rd_value     (rd_value       )
    );

    arm_execute arm_execute_0 (
        .clk            (clk            ), .i_rst       (i_rst          ),
        .i_vld          (id_vld         ), .i_class     (id_class       ),
        .i_op           (id_op          ), .i_cond      (id_cond        ),
        .i_set_flags    (id_set_flags   ), .i_op_a      (id_op_a        ),
        .i_op_b         (id_op_b        ), .i_store_data (id_store_data ),
        .i_dest         (id_dest        ), .i_writes_rd (id_writes_rd   ),
        .i_target       (id_target      ),
        .o_res_en       (ex_en          ), .o_res_code  (ex_code        ),
        .o_res_value    (ex_value       ), .o_load      (ex_load        ),
        .o_branch       (branch         ), .o_branch_target (branch_target),
        .o_ram_en       (o_ram_en       ), .o_ram_wr    (o_ram_wr       ),
        .o_ram_addr     (o_ram_addr     ), .o_ram_wdata (o_ram_wdata    )
    );

    arm_writeback arm_writeback_0 (
        .clk            (clk            ), .i_rst       (i_rst          ),
        .i_res_en       (ex_en          ), .i_res_code  (ex_code        ),
        .i_res_value    (ex_value       ), .i_load      (ex_load        ),
        .i_ram_rdata    (i_ram_rdata    ),
        .o_wb_en        (wb_en          ), .o_wb_code   (wb_code        ),
        .o_wb_value     (wb_value       )
    );

endmodule

// File: verif/tb_arm_core.sv
`timescale 1ns/1ps
`include "arm_cfg.svh"

module tb_arm_core;
    import arm_isa_pkg::*;
    import arm_core_pkg::*;

    localparam int PROG_LEN   = 96;             // random body, eight final stores, closing loop
    localparam int BODY_LEN   = PROG_LEN - 9;
    localparam int ROM_WORDS  = PROG_LEN + 8;
    localparam int RAM_WORDS  = 64;
    localparam int RST_CYCLES = 10;
    localparam logic [31:0] SEED = 32'h400f_1449;

    logic  clk;
    logic  i_rst;
    logic  o_rom_en, o_ram_en, o_ram_wr;
    word_t o_rom_addr, i_rom_data, o_ram_addr, i_ram_rdata, o_ram_wdata;

    word_t       rom [ROM_WORDS];
    word_t       ram [RAM_WORDS];
    logic [31:0] lcg_state;
    int          cyc, seen, total_req;
    int          checks [4];
    int          errors [4];

    // expected bus activity from the isa model, oldest first
    logic  exp_wr [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_target [$];

    logic  rom_pend, ram_pend;
    word_t rom_pend_addr, ram_pend_addr, last_fetch;

    arm_core i_arm_core (
        .clk         (clk        ),
        .i_rst       (i_rst      ),
        .o_rom_en    (o_rom_en   ),
        .o_rom_addr  (o_rom_addr ),
        .i_rom_data  (i_rom_data ),
        .o_ram_en    (o_ram_en   ),
        .o_ram_wr    (o_ram_wr   ),
        .o_ram_addr  (o_ram_addr ),
        .i_ram_rdata (i_ram_rdata),
        .o_ram_wdata (o_ram_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;                  // low bits of the lcg repeat quickly
    endfunction

    function automatic word_t ram_fill(input int idx);
        return 32'hd00d_0000 ^ (word_t'(idx) * 32'h0001_0203);
    endfunction

    function automatic word_t rom_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < ROM_WORDS)
            return rom[idx];
        return '0;
    endfunction

    function automatic word_t rot_imm(input logic [11:0] f);
        word_t v;
        v = word_t'(f[7:0]);
        return (v >> (2 * f[11:8])) | (v << (32 - 2 * f[11:8]));
    endfunction

    // odd codes are the inverse of the even code below them
    function automatic logic cond_holds(input logic [3:0] c, input nzcv_t f);
        logic n, z, cf, v, t;
        {n, z, cf, v} = f;
        case (c[3:1])
            3'd0:    t = z;
            3'd1:    t = cf;
            3'd2:    t = n;
            3'd3:    t = v;
            3'd4:    t = cf && !z;
            3'd5:    t = n == v;
            3'd6:    t = !z && n == v;
            default: t = 1'b1;
        endcase
        return (c == COND_NV) ? 1'b0 : t ^ c[0];
    endfunction

    task automatic build_program();
        logic [31:0] r, r2;
        logic [3:0]  cond, op, rd, rn, rm;
        logic        s;
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = '0;
        for (int i = 0; i < BODY_LEN; i++) begin
            r    = lcg_next();
            r2   = lcg_next();
            cond = r[20] ? 4'hE : r[3:0];       // half of them unconditional
            rd   = {1'b0, r[14:12]};
            rn   = {1'b0, r[18:16]};
            rm   = {1'b0, r[6:4]};
            op   = r2[3:0];
            if (op inside {4'd5, 4'd6, 4'd7})
                op = op + 4'd8;                 // no carry-in ops
            s = r2[4] || op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
            if (op == OP_MOV || op == OP_MVN)
                rn = 4'd0;
            case (r[10:8])
                3'd5:    rom[i] = {cond, 8'h59, 4'd8, rd, 4'h0, r2[11:6], 2'b00};
                3'd6:    rom[i] = {cond, 8'h58, 4'd8, rd, 4'h0, r2[11:6], 2'b00};
                3'd7:    rom[i] = {cond, 4'hA, 24'(2 * (r2 % 3))};    // skips 1, 3 or 5
                default: rom[i] = {cond, 2'b00, r2[5], op, s, rn, rd,
                                   r2[5] ? {r2[17:14], r2[13:6]} : {8'h00, rm}};
            endcase
        end
        for (int j = 0; j < 8; j++)
            rom[BODY_LEN + j] = {4'hE, 8'h58, 4'd8, 4'(j), 4'h0, 6'(56 + j), 2'b00};
        rom[PROG_LEN - 1] = {4'hE, 4'hA, 24'hFF_FFFE};  // branch to itself
    endtask

    // instruction set model, base register r8 stays zero
    task automatic run_model();
        word_t       regs [16];
        word_t       mem [RAM_WORDS];
        nzcv_t       fl;
        word_t       pc, pc_next, inst, a, b, res, tgt;
        logic        c, v;
        logic [32:0] wide;
        dp_op_e      op;
        int          steps;
        for (int i = 0; i < 16; i++)
            regs[i] = '0;
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = ram_fill(i);
        fl    = '0;
        pc    = `ARM_RESET_PC;
        steps = 0;
        while (steps <= PROG_LEN) begin
            inst    = rom_word(pc);
            pc_next = pc + 32'd4;
            steps++;
            if (cond_holds(inst[COND_LSB +: 4], fl)) begin
                case (inst[27:26])
                    2'b10: begin
                        tgt = pc + `ARM_PC_AHEAD + {{6{inst[23]}}, inst[23:0], 2'b00};
                        exp_target.push_back(tgt);
                        if (tgt == pc)
                            break;
                        pc_next = tgt;
                    end
                    2'b01: begin
                        a = regs[inst[RN_LSB +: 4]] + (inst[BIT_UP] ? word_t'(inst[11:0])
                                                                     : -word_t'(inst[11:0]));
                        exp_wr.push_back(!inst[BIT_SET]);
                        exp_addr.push_back(a);
                        if (inst[BIT_SET]) begin
                            regs[inst[RD_LSB +: 4]] = mem[a[7:2]];
                            exp_data.push_back('0);
                        end else begin
                            mem[a[7:2]] = regs[inst[RD_LSB +: 4]];
                            exp_data.push_back(regs[inst[RD_LSB +: 4]]);
                        end
                    end
                    default: begin
                        op = dp_op_e'(inst[OP_LSB +: 4]);
                        a  = regs[inst[RN_LSB +: 4]];
                        b  = inst[BIT_IMM] ? rot_imm(inst[11:0]) : regs[inst[3:0]];
                        c  = fl[1];
                        v  = fl[0];
                        case (op)
                            OP_AND, OP_TST: res = a & b;
                            OP_EOR, OP_TEQ: res = a ^ b;
                            OP_ORR:         res = a | b;
                            OP_BIC:         res = a & ~b;
                            OP_MOV:         res = b;
                            OP_MVN:         res = ~b;
                            OP_SUB, OP_CMP: begin
                                res = a - b;
                                c   = a >= b;           // carry means no borrow
                                v   = (a[31] != b[31]) && (res[31] != a[31]);
                            end
                            OP_RSB: begin
                                res = b - a;
                                c   = b >= a;
                                v   = (a[31] != b[31]) && (res[31] != b[31]);
                            end
                            default: begin
                                wide = {1'b0, a} + {1'b0, b};
                                res  = wide[31:0];
                                c    = wide[32];
                                v    = (a[31] == b[31]) && (res[31] != a[31]);
                            end
                        endcase
                        if (inst[BIT_SET])
                            fl = {res[31], res == '0, c, v};
                        if (!(op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}))
                            regs[inst[RD_LSB +: 4]] = res;
                    end
                endcase
            end
            pc = pc_next;
        end
    endtask

    task automatic check_reset();
        checks[0]++;
        assert (o_rom_addr == `ARM_RESET_PC) else begin
            $display("Fail at %0t: o_rom_addr = %h, expected %h",
                     $time, o_rom_addr, `ARM_RESET_PC);
            errors[0]++;
        end
        assert (o_rom_en) else begin
            $display("Fail at %0t: o_rom_en = %b, expected 1", $time, o_rom_en);
            errors[0]++;
        end
        assert (!o_ram_en) else begin
            $display("Fail at %0t: o_ram_en = %b, expected 0", $time, o_ram_en);
            errors[0]++;
        end
    endtask

    task automatic check_bus();
        logic  wr;
        word_t addr, data, tgt;
        if (o_ram_en) begin
            seen++;
            checks[1]++;
            assert (exp_wr.size() > 0) else begin
                $display("RAM request at %0t to %h after the program's last one",
                         $time, o_ram_addr);
                errors[1]++;
            end
            if (exp_wr.size() > 0) begin
                wr   = exp_wr.pop_front();
                addr = exp_addr.pop_front();
                data = exp_data.pop_front();
                assert (o_ram_wr == wr) else begin
                    $display("Fail at %0t: o_ram_wr = %b, expected %b", $time, o_ram_wr, wr);
                    errors[1]++;
                end
                assert (o_ram_addr == addr) else begin
                    $display("Fail at %0t: o_ram_addr = %h, expected %h", $time, o_ram_addr, addr);
                    errors[1]++;
                end
                if (wr)
                    assert (o_ram_wdata == data) else begin
                        $display("Fail at %0t: o_ram_wdata = %h, expected %h",
                                 $time, o_ram_wdata, data);
                        errors[1]++;
                    end
            end
            if (o_ram_wr)
                ram[o_ram_addr[7:2]] = o_ram_wdata;
        end
        // a fetch that does not follow the previous one is a branch redirect
        if (o_rom_en && !i_rst) begin
            if (o_rom_addr != last_fetch + 32'd4 && exp_target.size() > 0) begin
                checks[2]++;
                tgt = exp_target.pop_front();
                assert (o_rom_addr == tgt) else begin
                    $display("Fail at %0t: o_rom_addr = %h, expected %h", $time, o_rom_addr, tgt);
                    errors[2]++;
                end
            end
            last_fetch = o_rom_addr;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        cyc++;
        i_rst = cyc < RST_CYCLES;
        if (rom_pend)
            i_rom_data = rom_word(rom_pend_addr);
        if (ram_pend)
            i_ram_rdata = ram[ram_pend_addr[7:2]];
        #1;                                     // let the stall path settle
        if (cyc <= RST_CYCLES)
            check_reset();
        check_bus();
        rom_pend      = o_rom_en;
        rom_pend_addr = o_rom_addr;
        ram_pend      = o_ram_en && !o_ram_wr;
        ram_pend_addr = o_ram_addr;
    endtask

    initial begin
        int sum_checks, sum_errors;
        i_rst       = 1'b1;
        i_rom_data  = '0;
        i_ram_rdata = '0;
        lcg_state   = SEED;
        cyc         = 0;
        seen        = 0;
        rom_pend    = 1'b0;
        ram_pend    = 1'b0;
        last_fetch  = `ARM_RESET_PC - 32'd4;
        for (int i = 0; i < 4; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < RAM_WORDS; i++)
            ram[i] = ram_fill(i);
        build_program();
        run_model();
        total_req = exp_wr.size();
        repeat (RST_CYCLES) step_cycle();
        $display("reset state:    %0d checks, %0d errors", checks[0], errors[0]);
        while (exp_wr.size() > 0)
            step_cycle();
        repeat (12) step_cycle();               // closing loop runs, nothing more on ram
        $display("ram requests:   %0d checks, %0d errors", checks[1], errors[1]);
        $display("branch targets: %0d checks, %0d errors", checks[2], errors[2]);
        checks[3] += 2;
        assert (seen == total_req) else begin
            $display("Fail at %0t: RAM request count = %0d, expected %0d", $time, seen, total_req);
            errors[3]++;
        end
        assert (exp_target.size() == 0) else begin
            $display("%0d taken branches never redirected fetch", exp_target.size());
            errors[3]++;
        end
        $display("completion:     %0d checks, %0d errors", checks[3], errors[3]);
        sum_checks = 0;
        sum_errors = 0;
        for (int i = 0; i < 4; i++) begin
            sum_checks += checks[i];
            sum_errors += errors[i];
        end
        $display("total: %0d checks, %0d errors", sum_checks, sum_errors);
        if (sum_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #((RST_CYCLES + 4 * PROG_LEN) * 10);
        $display("watchdog expired at %0t with %0d RAM requests outstanding",
                 $time, exp_wr.size());
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+common
common/arm_isa_pkg.sv
common/arm_core_pkg.sv
core/arm_fetch.sv
core/arm_decoder.sv
core/arm_regfile.sv
core/arm_execute.sv
core/arm_writeback.sv
core/arm_core.sv
verif/tb_arm_core.sv

// File: Makefile
TOP = tb_arm_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
